// ==== src/tlb_entry_pkg.sv ====
package tlb_entry_pkg;

    localparam int TLB_VPPN_W = 19;
    localparam int TLB_PPN_W  = 20;
    localparam int TLB_ASID_W = 10;
    localparam int TLB_IDX_W  = 5;

    // page size codes held in the ps field
    localparam logic [5:0] TLB_PS_4K = 6'd12;
    localparam logic [5:0] TLB_PS_2M = 6'd21;

    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;

    // one half of an even/odd page pair
    typedef struct packed {
        logic [TLB_PPN_W-1:0] ppn;
        logic [1:0]           plv;
        logic [1:0]           mat;
        logic                 d;
        logic                 v;
    } tlb_page_t;

    typedef struct packed {
        logic                  e;
        logic [TLB_VPPN_W-1:0] vppn;
        logic [5:0]            ps;
        logic [TLB_ASID_W-1:0] asid;
        logic                  g;
        tlb_page_t             page0;
        tlb_page_t             page1;
    } tlb_entry_t;

    // search result, page already picked by the va
    typedef struct packed {
        logic      found;
        tlb_idx_t  index;
        tlb_page_t page;
    } tlb_match_t;

endpackage

// ==== src/tlb_cmd_pkg.sv ====
package tlb_cmd_pkg;

    import tlb_entry_pkg::*;

    // same encoding as the raw op at the top port
    typedef enum logic [1:0] {
        TLB_SRCH = 2'd0,
        TLB_RD   = 2'd1,
        TLB_WR   = 2'd2,
        TLB_INV  = 2'd3
    } tlb_op_e;

    // invtlb op codes
    typedef enum logic [2:0] {
        INV_ALL0      = 3'd0,
        INV_ALL1      = 3'd1,
        INV_GLOBAL    = 3'd2,
        INV_NONGLOBAL = 3'd3,
        INV_ASID      = 3'd4,
        INV_ASID_VA   = 3'd5,
        INV_GASID_VA  = 3'd6
    } invtlb_op_e;

    typedef struct packed {
        tlb_op_e               op;
        invtlb_op_e            inv_op;
        logic                  illegal;
        tlb_idx_t              index;
        logic [TLB_ASID_W-1:0] asid;
        logic [31:0]           vaddr;
        tlb_entry_t            entry;
    } tlb_cmd_t;

endpackage

// ==== src/tlb_cmd_if.sv ====
`timescale 1ns/100ps

interface tlb_cmd_if import tlb_cmd_pkg::*; ();

    logic     valid;
    logic     ready;
    tlb_cmd_t cmd;

    modport producer (
        output valid,
        output cmd,
        input  ready
    );

    modport consumer (
        input  valid,
        input  cmd,
        output ready
    );

endinterface

// ==== src/tlb_cmd_decode.sv ====
`timescale 1ns/100ps

module tlb_cmd_decode
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
(
    input  logic                  aclk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  logic [1:0]            cmd_op,
    input  logic [4:0]            cmd_inv_op,
    input  tlb_idx_t              cmd_index,
    input  logic [TLB_ASID_W-1:0] cmd_asid,
    input  logic [31:0]           cmd_vaddr,
    input  tlb_entry_t            cmd_entry,
    tlb_cmd_if.producer           cmd_out
);

    tlb_cmd_t dec_cmd;
    logic     accept;

    // stage is free when empty or draining this cycle
    assign cmd_ready = !cmd_out.valid || cmd_out.ready;
    assign accept    = cmd_valid && cmd_ready;

    always_comb begin
        dec_cmd.op      = tlb_op_e'(cmd_op);
        dec_cmd.inv_op  = invtlb_op_e'(cmd_inv_op[2:0]);
        // only codes 0..6 exist
        dec_cmd.illegal = (tlb_op_e'(cmd_op) == TLB_INV) && (cmd_inv_op > 5'd6);
        dec_cmd.index   = cmd_index;
        dec_cmd.asid    = cmd_asid;
        dec_cmd.vaddr   = cmd_vaddr;
        dec_cmd.entry   = cmd_entry;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            cmd_out.valid <= 1'b0;
        end else if (accept) begin
            cmd_out.valid <= 1'b1;
        end else if (cmd_out.ready) begin
            cmd_out.valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            cmd_out.cmd <= dec_cmd;
        end
    end

    // held command must not change until the fifo takes it
    a_hold_stable: assert property (
        @(posedge aclk) disable iff (rst)
        cmd_out.valid && !cmd_out.ready |=> cmd_out.valid && $stable(cmd_out.cmd)
    );

endmodule

// ==== src/tlb_cmd_fifo.sv ====
`timescale 1ns/100ps

module tlb_cmd_fifo
    import tlb_cmd_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic        aclk,
    input  logic        rst,
    tlb_cmd_if.consumer push,
    tlb_cmd_if.producer pop
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    tlb_cmd_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign push.ready = (count != CNT_W'(FIFO_DEPTH));
    assign pop.valid  = (count != '0);
    assign pop.cmd    = mem[rd_ptr];

    assign wr_en = push.valid && push.ready;
    assign rd_en = pop.valid && pop.ready;

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push.cmd;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_write_full: assert property (
        @(posedge aclk) disable iff (rst)
        (count == CNT_W'(FIFO_DEPTH)) && !rd_en |=> wr_ptr == $past(wr_ptr)
    );

    a_no_read_empty: assert property (
        @(posedge aclk) disable iff (rst)
        (count == '0) |=> rd_ptr == $past(rd_ptr)
    );

endmodule

// ==== src/tlb_entry_array.sv ====
`timescale 1ns/100ps

module tlb_entry_array
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
#(
    parameter int TLBNUM = 16
)
(
    input  logic                  aclk,
    input  logic                  rst,
    input  logic [31:0]           srch_vaddr,
    input  logic [TLB_ASID_W-1:0] srch_asid,
    output tlb_match_t            srch_result,
    input  tlb_idx_t              rd_index,
    output tlb_entry_t            rd_entry,
    input  logic                  we,
    input  tlb_idx_t              w_index,
    input  tlb_entry_t            w_entry,
    input  logic                  inv_valid,
    input  invtlb_op_e            inv_op
);

    localparam int IDX_W = $clog2(TLBNUM);

    tlb_entry_t            ent [TLBNUM];
    logic [TLB_VPPN_W-1:0] srch_vppn;
    logic [TLBNUM-1:0]     va_match;
    logic [TLBNUM-1:0]     asid_match;
    logic [TLBNUM-1:0]     hit;
    logic [TLBNUM-1:0]     inv_clr;

    assign srch_vppn = srch_vaddr[31:13];

    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            // 2MB pages ignore the low 9 vppn bits
            if (ent[i].ps == TLB_PS_2M) begin
                va_match[i] = (ent[i].vppn[18:9] == srch_vppn[18:9]);
            end else begin
                va_match[i] = (ent[i].vppn == srch_vppn);
            end
            asid_match[i] = (ent[i].asid == srch_asid);
            hit[i]        = ent[i].e && (ent[i].g || asid_match[i]) && va_match[i];
            case (inv_op)
                INV_ALL0, INV_ALL1: inv_clr[i] = 1'b1;
                INV_GLOBAL:         inv_clr[i] = ent[i].g;
                INV_NONGLOBAL:      inv_clr[i] = !ent[i].g;
                INV_ASID:           inv_clr[i] = !ent[i].g && asid_match[i];
                INV_ASID_VA:        inv_clr[i] = !ent[i].g && asid_match[i] && va_match[i];
                INV_GASID_VA:       inv_clr[i] = (ent[i].g || asid_match[i]) && va_match[i];
                default:            inv_clr[i] = 1'b0;
            endcase
        end
    end

    // walk downwards so the lowest hitting index is left
    always_comb begin
        srch_result = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                srch_result.found = 1'b1;
                srch_result.index = tlb_idx_t'(i);
                if (ent[i].ps == TLB_PS_2M) begin
                    srch_result.page = srch_vaddr[21] ? ent[i].page1 : ent[i].page0;
                end else begin
                    srch_result.page = srch_vaddr[12] ? ent[i].page1 : ent[i].page0;
                end
            end
        end
    end

    assign rd_entry = ent[rd_index[IDX_W-1:0]];

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < TLBNUM; i++) begin
                ent[i].e <= 1'b0;
            end
        end else if (we) begin
            ent[w_index[IDX_W-1:0]] <= w_entry;
        end else if (inv_valid) begin
            for (int i = 0; i < TLBNUM; i++) begin
                if (inv_clr[i]) begin
                    ent[i].e <= 1'b0;
                end
            end
        end
    end

    // engine issues one update per cycle
    a_one_update: assert property (
        @(posedge aclk) disable iff (rst)
        !(we && inv_valid)
    );

endmodule

// ==== src/tlb_engine.sv ====
`timescale 1ns/100ps

module tlb_engine
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
#(
    parameter int TLBNUM = 16
)
(
    input  logic        aclk,
    input  logic        rst,
    tlb_cmd_if.consumer cmd_in,
    output logic        resp_valid,
    input  logic        resp_ready,
    output tlb_op_e     resp_op,
    output logic        resp_err,
    output logic        resp_found,
    output tlb_idx_t    resp_index,
    output tlb_page_t   resp_page,
    output tlb_entry_t  resp_entry
);

    logic       pop;
    tlb_match_t srch_result;
    tlb_entry_t rd_entry;
    logic       nxt_found;
    tlb_idx_t   nxt_index;
    tlb_page_t  nxt_page;
    tlb_entry_t nxt_entry;

    assign cmd_in.ready = !resp_valid || resp_ready;
    assign pop          = cmd_in.valid && cmd_in.ready;

    tlb_entry_array #(
        .TLBNUM      (TLBNUM)
    ) u_array (
        .aclk        (aclk),
        .rst         (rst),
        .srch_vaddr  (cmd_in.cmd.vaddr),
        .srch_asid   (cmd_in.cmd.asid),
        .srch_result (srch_result),
        .rd_index    (cmd_in.cmd.index),
        .rd_entry    (rd_entry),
        .we          (pop && (cmd_in.cmd.op == TLB_WR)),
        .w_index     (cmd_in.cmd.index),
        .w_entry     (cmd_in.cmd.entry),
        .inv_valid   (pop && (cmd_in.cmd.op == TLB_INV) && !cmd_in.cmd.illegal),
        .inv_op      (cmd_in.cmd.inv_op)
    );

    // write and invalidate answer with zero data
    always_comb begin
        nxt_found = 1'b0;
        nxt_index = '0;
        nxt_page  = '0;
        nxt_entry = '0;
        case (cmd_in.cmd.op)
            TLB_SRCH: begin
                nxt_found = srch_result.found;
                nxt_index = srch_result.index;
                nxt_page  = srch_result.page;
            end
            TLB_RD: begin
                nxt_found = rd_entry.e;
                nxt_entry = rd_entry;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (pop) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            resp_op    <= cmd_in.cmd.op;
            resp_err   <= cmd_in.cmd.illegal;
            resp_found <= nxt_found;
            resp_index <= nxt_index;
            resp_page  <= nxt_page;
            resp_entry <= nxt_entry;
        end
    end

    a_resp_hold: assert property (
        @(posedge aclk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_op) && $stable(resp_err)
            && $stable(resp_found) && $stable(resp_index) && $stable(resp_page)
            && $stable(resp_entry)
    );

endmodule

// ==== src/tlb_unit_top.sv ====
`timescale 1ns/100ps

module tlb_unit_top
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
#(
    parameter int TLBNUM     = 16,
    parameter int FIFO_DEPTH = 4
)
(
    input  logic                  aclk,
    input  logic                  rst,
    // command port
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  logic [1:0]            cmd_op,
    input  logic [4:0]            cmd_inv_op,
    input  tlb_idx_t              cmd_index,
    input  logic [TLB_ASID_W-1:0] cmd_asid,
    input  logic [31:0]           cmd_vaddr,
    input  tlb_entry_t            cmd_entry,
    // response port
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output tlb_op_e               resp_op,
    output logic                  resp_err,
    output logic                  resp_found,
    output tlb_idx_t              resp_index,
    output tlb_page_t             resp_page,
    output tlb_entry_t            resp_entry
);

    tlb_cmd_if cmd_dec_to_fifo ();
    tlb_cmd_if cmd_fifo_to_eng ();

    tlb_cmd_decode u_decode (
        .aclk       (aclk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_inv_op (cmd_inv_op),
        .cmd_index  (cmd_index),
        .cmd_asid   (cmd_asid),
        .cmd_vaddr  (cmd_vaddr),
        .cmd_entry  (cmd_entry),
        .cmd_out    (cmd_dec_to_fifo.producer)
    );

    tlb_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .aclk       (aclk),
        .rst        (rst),
        .push       (cmd_dec_to_fifo.consumer),
        .pop        (cmd_fifo_to_eng.producer)
    );

    tlb_engine #(
        .TLBNUM     (TLBNUM)
    ) u_engine (
        .aclk       (aclk),
        .rst        (rst),
        .cmd_in     (cmd_fifo_to_eng.consumer),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_op    (resp_op),
        .resp_err   (resp_err),
        .resp_found (resp_found),
        .resp_index (resp_index),
        .resp_page  (resp_page),
        .resp_entry (resp_entry)
    );

endmodule

// ==== verif/tlb_model.svh ====
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

// one expected response, queued at the command handshake
typedef struct packed {
    tlb_op_e    op;
    logic       err;
    logic       found;
    tlb_idx_t   index;
    tlb_page_t  page;
    tlb_entry_t entry;
    logic       full_entry;
} exp_resp_t;

tlb_entry_t ref_ent   [TLBNUM];
bit         ref_known [TLBNUM];

function automatic void clear_contents();
    for (int i = 0; i < TLBNUM; i++) begin
        ref_ent[i]   = '0;
        ref_known[i] = 1'b0;
    end
endfunction

// 2MB pages look at va bits 31..22 only
function automatic bit va_covers(tlb_entry_t ent, logic [31:0] va);
    if (ent.ps == 6'd21) begin
        return ent.vppn[18:9] == va[31:22];
    end
    return ent.vppn == va[31:13];
endfunction

function automatic bit inv_selects(logic [2:0] code, tlb_entry_t ent,
                                   logic [TLB_ASID_W-1:0] asid, logic [31:0] va);
    bit same_asid;
    same_asid = (ent.asid == asid);
    case (code)
        3'd2:    return ent.g;
        3'd3:    return !ent.g;
        3'd4:    return !ent.g && same_asid;
        3'd5:    return !ent.g && same_asid && va_covers(ent, va);
        3'd6:    return (ent.g || same_asid) && va_covers(ent, va);
        default: return 1'b1;
    endcase
endfunction

function automatic exp_resp_t apply_command(tlb_op_e op, logic [4:0] inv, int idx,
                                            logic [TLB_ASID_W-1:0] asid, logic [31:0] va,
                                            tlb_entry_t ent);
    exp_resp_t r;
    logic      odd;
    r    = '0;
    r.op = op;
    case (op)
        TLB_SRCH: begin
            for (int i = 0; i < TLBNUM; i++) begin
                if (!r.found && ref_ent[i].e && (ref_ent[i].g || ref_ent[i].asid == asid)
                        && va_covers(ref_ent[i], va)) begin
                    r.found = 1'b1;
                    r.index = tlb_idx_t'(i);
                    odd     = (ref_ent[i].ps == 6'd21) ? va[21] : va[12];
                    r.page  = odd ? ref_ent[i].page1 : ref_ent[i].page0;
                end
            end
        end
        TLB_RD: begin
            r.found      = ref_ent[idx].e;
            r.entry      = ref_ent[idx];
            r.full_entry = ref_known[idx];
        end
        TLB_WR: begin
            ref_ent[idx]   = ent;
            ref_known[idx] = 1'b1;
        end
        default: begin
            // codes above 6 leave the table alone
            if (inv > 5'd6) begin
                r.err = 1'b1;
            end else begin
                for (int i = 0; i < TLBNUM; i++) begin
                    if (inv_selects(inv[2:0], ref_ent[i], asid, va)) begin
                        ref_ent[i].e = 1'b0;
                    end
                end
            end
        end
    endcase
    return r;
endfunction

`endif

// ==== verif/tb_tlb_unit.sv ====
`timescale 1ns/100ps

module tb_tlb_unit
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
;

    localparam int TLBNUM  = 16;
    localparam int TIMEOUT = 1000;

    `include "tlb_model.svh"

    logic                  aclk = 1'b0;
    logic                  rst;
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic [1:0]            cmd_op;
    logic [4:0]            cmd_inv_op;
    tlb_idx_t              cmd_index;
    logic [TLB_ASID_W-1:0] cmd_asid;
    logic [31:0]           cmd_vaddr;
    tlb_entry_t            cmd_entry;
    logic                  resp_valid;
    logic                  resp_ready;
    tlb_op_e               resp_op;
    logic                  resp_err;
    logic                  resp_found;
    tlb_idx_t              resp_index;
    tlb_page_t             resp_page;
    tlb_entry_t            resp_entry;

    exp_resp_t exp_q [$];
    int        err_count  = 0;
    int        timeouts   = 0;
    int        checked    = 0;
    bit        slow_drain = 1'b0;
    bit        stalled;
    exp_resp_t held;

    tlb_unit_top #(
        .TLBNUM     (TLBNUM),
        .FIFO_DEPTH (4)
    ) UUT (
        .aclk       (aclk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_inv_op (cmd_inv_op),
        .cmd_index  (cmd_index),
        .cmd_asid   (cmd_asid),
        .cmd_vaddr  (cmd_vaddr),
        .cmd_entry  (cmd_entry),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_op    (resp_op),
        .resp_err   (resp_err),
        .resp_found (resp_found),
        .resp_index (resp_index),
        .resp_page  (resp_page),
        .resp_entry (resp_entry)
    );

    always #2 aclk = ~aclk;

    // small vppn pool so searches and invalidates actually hit
    function automatic logic [18:0] rand_vppn();
        logic [18:0] v;
        v       = '0;
        v[10:9] = 2'($urandom_range(0, 3));
        v[8]    = 1'($urandom_range(0, 1));
        v[0]    = 1'($urandom_range(0, 1));
        return v;
    endfunction

    function automatic logic [31:0] rand_vaddr();
        return {rand_vppn(), 1'($urandom_range(0, 1)), 12'($urandom)};
    endfunction

    function automatic logic [TLB_ASID_W-1:0] rand_asid();
        return TLB_ASID_W'($urandom_range(0, 3));
    endfunction

    function automatic tlb_entry_t rand_entry();
        tlb_entry_t e;
        e.e     = ($urandom_range(0, 7) != 0);
        e.vppn  = rand_vppn();
        e.ps    = ($urandom_range(0, 1) != 0) ? 6'd21 : 6'd12;
        e.asid  = rand_asid();
        e.g     = ($urandom_range(0, 3) == 0);
        e.page0 = tlb_page_t'(25'($urandom));
        e.page1 = tlb_page_t'(25'($urandom));
        return e;
    endfunction

    function automatic exp_resp_t observed();
        exp_resp_t o;
        o       = '0;
        o.op    = resp_op;
        o.err   = resp_err;
        o.found = resp_found;
        o.index = resp_index;
        o.page  = resp_page;
        o.entry = resp_entry;
        return o;
    endfunction

    // holds the command until cmd_ready, then updates the model
    task automatic send_cmd(input tlb_op_e op, input logic [4:0] inv, input int idx,
                            input logic [TLB_ASID_W-1:0] asid, input logic [31:0] va,
                            input tlb_entry_t ent);
        int waited;
        if (timeouts != 0) begin
            return;
        end
        cmd_valid  = 1'b1;
        cmd_op     = op;
        cmd_inv_op = inv;
        cmd_index  = tlb_idx_t'(idx);
        cmd_asid   = asid;
        cmd_vaddr  = va;
        cmd_entry  = ent;
        waited     = 0;
        @(posedge aclk);
        while (!cmd_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                timeouts++;
                $display("Timeout at %0d ns: cmd_ready stayed low for %0d cycles", $time,
                         TIMEOUT);
                return;
            end
            @(posedge aclk);
        end
        exp_q.push_back(apply_command(op, inv, idx, asid, va, ent));
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic send_search();
        send_cmd(TLB_SRCH, 5'd0, 0, rand_asid(), rand_vaddr(), '0);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && timeouts == 0) begin
            @(posedge aclk);
            waited++;
            if (waited > TIMEOUT) begin
                timeouts++;
                $display("Timeout at %0d ns: %0d responses never arrived", $time, exp_q.size());
            end
        end
    endtask

    task automatic check_response(input exp_resp_t e);
        checked++;
        if (resp_op != e.op) begin
            err_count++;
            $display("Error at %0d ns: resp_op %0d, expected %0d", $time, resp_op, e.op);
        end
        if (resp_err != e.err) begin
            err_count++;
            $display("Error at %0d ns: resp_err %0b, expected %0b", $time, resp_err, e.err);
        end
        if (resp_found != e.found) begin
            err_count++;
            $display("Error at %0d ns: resp_found %0b, expected %0b", $time, resp_found,
                     e.found);
        end
        if (resp_index != e.index) begin
            err_count++;
            $display("Error at %0d ns: resp_index %0d, expected %0d", $time, resp_index,
                     e.index);
        end
        if (resp_page != e.page) begin
            err_count++;
            $display("Error at %0d ns: resp_page %h, expected %h", $time, resp_page, e.page);
        end
        // a never written entry only has a defined e bit
        if ((e.op != TLB_RD || e.full_entry) && resp_entry != e.entry) begin
            err_count++;
            $display("Error at %0d ns: resp_entry %h, expected %h", $time, resp_entry,
                     e.entry);
        end
    endtask

    // response side with random back-pressure
    initial begin
        resp_ready = 1'b0;
        stalled    = 1'b0;
        held       = '0;
        forever begin
            @(posedge aclk);
            if (!rst) begin
                if (stalled && (!resp_valid || observed() != held)) begin
                    err_count++;
                    $display("Error at %0d ns: response changed while stalled", $time);
                end
                if (resp_valid && resp_ready) begin
                    if (exp_q.size() == 0) begin
                        err_count++;
                        $display("Error at %0d ns: response with no command outstanding",
                                 $time);
                    end else begin
                        check_response(exp_q.pop_front());
                    end
                end
                stalled = resp_valid && !resp_ready;
                held    = observed();
            end
            #1;
            if (slow_drain) begin
                resp_ready = ($urandom_range(0, 3) == 0);
            end else begin
                resp_ready = ($urandom_range(0, 3) != 0);
            end
        end
    end

    initial begin
        int pick;
        void'($urandom(73));
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = '0;
        cmd_inv_op = '0;
        cmd_index  = '0;
        cmd_asid   = '0;
        cmd_vaddr  = '0;
        cmd_entry  = '0;
        clear_contents();
        repeat (10) @(posedge aclk);
        #1;
        rst = 1'b0;

        // empty after reset
        for (int i = 0; i < TLBNUM; i++) begin
            send_cmd(TLB_RD, 5'd0, i, '0, '0, '0);
        end
        repeat (8) send_search();

        for (int i = 0; i < TLBNUM; i++) begin
            send_cmd(TLB_WR, 5'd0, i, '0, '0, rand_entry());
            send_cmd(TLB_RD, 5'd0, i, '0, '0, '0);
        end
        repeat (200) send_search();

        // codes 0..6, then 7, 8 and 31 as illegal
        for (int code = 0; code < 10; code++) begin
            for (int i = 0; i < TLBNUM; i++) begin
                send_cmd(TLB_WR, 5'd0, i, '0, '0, rand_entry());
            end
            send_cmd(TLB_INV, 5'(code < 9 ? code : 31), 0, rand_asid(), rand_vaddr(), '0);
            for (int i = 0; i < TLBNUM; i++) begin
                send_cmd(TLB_RD, 5'd0, i, '0, '0, '0);
            end
            repeat (16) send_search();
        end

        // mixed traffic, heavy back-pressure in the second half
        for (int n = 0; n < 400; n++) begin
            if (n == 200) begin
                slow_drain = 1'b1;
            end
            pick = $urandom_range(0, 9);
            if (pick < 3) begin
                send_search();
            end else if (pick < 5) begin
                send_cmd(TLB_RD, 5'd0, $urandom_range(0, TLBNUM - 1), '0, '0, '0);
            end else if (pick < 8) begin
                send_cmd(TLB_WR, 5'd0, $urandom_range(0, TLBNUM - 1), '0, '0, rand_entry());
            end else begin
                send_cmd(TLB_INV, 5'($urandom_range(0, 8)), 0, rand_asid(), rand_vaddr(), '0);
            end
        end

        wait_drain();
        repeat (8) @(posedge aclk);
        $display("Summary: %0d responses checked, %0d errors, %0d timeouts", checked,
                 err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verif
src/tlb_entry_pkg.sv
src/tlb_cmd_pkg.sv
src/tlb_cmd_if.sv
src/tlb_cmd_decode.sv
src/tlb_cmd_fifo.sv
src/tlb_entry_array.sv
src/tlb_engine.sv
src/tlb_unit_top.sv
verif/tb_tlb_unit.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_tlb_unit

out=$(./obj_dir/Vtb_tlb_unit)
echo "$out"

# grep fails the script when the pass line is missing
echo "$out" | grep -q "ALL TESTS PASSED"
